//--- bench/mini_core_stim.hex
// Columns in hex digits: drive(1) inst(8) expect(1) rd(1) data(8)
// inst fields: opcode, rd, rs1, rs2, imm16
1910012341112340000 // LUI  r1, 0x1234
1811056781112345678 // ADDI r1, r1, 0x5678, bypass
18200FFF012FFFFFFF0 // ADDI r2, r0, -16
1131200001312345668 // ADD  r3, r1, r2, write-through and bypass
12431000014FFFFFFF0 // SUB  r4, r3, r1, bypass and register file
0000000000000000000 // idle
1351400001512345670 // AND  r5, r1, r4, write-through across a gap
187000F0F1700000F0F // ADDI r7, r0, 0x0F0F
0000000000000000000 // idle
1465700001612345F7F // OR   r6, r5, r7, register file and write-through
1586100001800000907 // XOR  r8, r6, r1
1890000041900000004 // ADDI r9, r0, 4
16A7900001A0000F0F0 // SLL  r10, r7, r9
17B1900001B01234567 // SRL  r11, r1, r9
1801000011012345679 // ADDI r0, r1, 1, commits but not stored
11C0000001C00000000 // ADD  r12, r0, r0, reads zero
10D1100000000000000 // NOP, no commit
1CE1100000000000000 // unknown opcode, no commit
18D0000211D00000021 // ADDI r13, r0, 33
16E1D00001E2468ACF0 // SLL  r14, r1, r13, low 5 bits only
12F0D00001FFFFFFFDF // SUB  r15, r0, r13

//--- all.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/issue_if.sv
hw/regfile_if.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/mini_core.sv
bench/mini_core_tb.sv

//--- bench/mini_core_tb.sv
// Testbench for the execution slice.
// Loads stimulus and expected commits from bench/mini_core_stim.hex, drives
// one entry per clock and checks each commit three edges after sampling.
// commit_count is compared against a tally kept here.

`default_nettype none

module mini_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_ENTRIES  = 64;
    // Edges from driving an entry until its commit is visible
    localparam int COMMIT_LAG   = 3;

    // [75:72] drive flag, [71:40] inst, [39:36] expect flag,
    // [35:32] expected rd, [31:0] expected data
    typedef logic [75:0] entry_t;

    logic               clock;
    logic               reset;
    logic               inst_valid;
    isa_pkg::inst_t     inst;
    logic               commit_valid;
    core_pkg::reg_idx_t commit_rd;
    core_pkg::data_t    commit_data;
    core_pkg::count_t   commit_count;

    entry_t           stim [MAX_ENTRIES];
    int               entry_count;
    int               cycle_count = 0;
    int               cycle_limit = 0;
    int               error_count = 0;
    int               pass_tests = 0;
    int               fail_tests = 0;
    core_pkg::count_t expected_count = '0;
    // Entries in flight, oldest first
    int               pending [$];

    mini_core u_mini_core (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_count (commit_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Run limit, armed once the entry count is known
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_rd(input core_pkg::reg_idx_t expected,
                            input core_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_rd expected %h actual %h", expected, actual);
            error_count++;
        end
    endtask

    task automatic check_data(input core_pkg::data_t expected,
                              input core_pkg::data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_data expected %h actual %h", expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input core_pkg::count_t expected,
                               input core_pkg::count_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_count expected %h actual %h", expected, actual);
            error_count++;
        end
    endtask

    // Book-keeping for one finished test
    task automatic report_test(input string label, input int errors_before);
        if (error_count == errors_before) begin
            pass_tests++;
            $display("%s ok", label);
        end else begin
            fail_tests++;
            $display("%s had %0d error(s)", label, error_count - errors_before);
        end
    endtask

    // Commit window of one entry, outputs sampled mid-cycle
    task automatic check_commit(input int idx);
        entry_t e;
        int     errors_before;
        e = stim[idx];
        errors_before = error_count;
        if (e[36]) begin
            expected_count = expected_count + 1'b1;
            if (commit_valid !== 1'b1) begin
                $display("Entry %0d expected a commit but none was reported", idx);
                error_count++;
            end else begin
                check_rd(e[35:32], commit_rd);
                check_data(e[31:0], commit_data);
            end
        end else if (commit_valid !== 1'b0) begin
            $display("Entry %0d should not commit but rd %0d was reported", idx, commit_rd);
            error_count++;
        end
        check_count(expected_count, commit_count);
        report_test($sformatf("Entry %0d", idx), errors_before);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int errors_before;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;

        $readmemh("bench/mini_core_stim.hex", stim);
        entry_count = 0;
        while ((entry_count < MAX_ENTRIES) && !$isunknown(stim[entry_count])) begin
            entry_count++;
        end
        cycle_limit = RESET_CYCLES + entry_count + 20;
        if (entry_count == 0) begin
            $display("No stimulus entries could be read from the data file");
            error_count++;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // Nothing committed straight out of reset
        @(negedge clock);
        errors_before = error_count;
        if (commit_valid !== 1'b0) begin
            $display("commit_valid is not low after reset");
            error_count++;
        end
        check_count('0, commit_count);
        report_test("Reset state", errors_before);

        // Drive one entry per edge, check the one three edges older
        for (int cycle = 0; cycle < entry_count + COMMIT_LAG; cycle++) begin
            @(posedge clock);
            if (cycle < entry_count) begin
                inst_valid <= stim[cycle][72];
                inst       <= stim[cycle][71:40];
                pending.push_back(cycle);
            end else begin
                inst_valid <= 1'b0;
                inst       <= '0;
            end
            @(negedge clock);
            if (cycle >= COMMIT_LAG) begin
                check_commit(pending.pop_front());
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/mini_core.sv
// Top level of the execution slice.
// Wires decode, execute and result together. One instruction per strobe
// on inst_valid, one commit report per real operation three stages later.

`default_nettype none

module mini_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               inst_valid,
    input  isa_pkg::inst_t     inst,
    output logic               commit_valid,
    output core_pkg::reg_idx_t commit_rd,
    output core_pkg::data_t    commit_data,
    output core_pkg::count_t   commit_count
);

    // Decode to execute
    issue_if   issue_bus ();
    // Decode reads, result answers
    regfile_if rf_bus ();

    // Execute back to decode, same cycle
    logic               bypass_valid;
    core_pkg::reg_idx_t bypass_rd;
    core_pkg::data_t    bypass_data;

    // Execute to result, registered
    logic               wb_valid;
    core_pkg::reg_idx_t wb_rd;
    core_pkg::data_t    wb_data;

    decode u_decode (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .bypass_valid (bypass_valid),
        .bypass_rd    (bypass_rd),
        .bypass_data  (bypass_data),
        .rf           (rf_bus.requester),
        .issue        (issue_bus.producer)
    );

    execute u_execute (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue_bus.consumer),
        .bypass_valid (bypass_valid),
        .bypass_rd    (bypass_rd),
        .bypass_data  (bypass_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    result u_result (
        .clock        (clock),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .rf           (rf_bus.provider),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_count (commit_count)
    );

endmodule

`default_nettype wire

//--- hw/result.sv
// Commit stage of the execution slice.
// Owns the register file, serves decode's two read ports with
// write-through, and registers the commit report and commit count.

`default_nettype none

module result (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_valid,
    input  core_pkg::reg_idx_t wb_rd,
    input  core_pkg::data_t    wb_data,
    regfile_if.provider        rf,
    output logic               commit_valid,
    output core_pkg::reg_idx_t commit_rd,
    output core_pkg::data_t    commit_data,
    output core_pkg::count_t   commit_count
);

    ////////////////////
    // Register file
    ////////////////////

    core_pkg::data_t regs [core_pkg::REG_COUNT];

    // Cleared on reset
    // Register 0 is never written
    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // One read port
    // Zero register first, then the value being written this cycle
    function automatic core_pkg::data_t read_reg(input core_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_valid && (wb_rd == idx)) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    // Distance-2 hazards resolve through the write-through above
    always_comb begin
        rf.rs1_data = read_reg(rf.rs1_idx);
        rf.rs2_data = read_reg(rf.rs2_idx);
    end

    ////////////////////
    // Commit report
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_count <= '0;
        end else begin
            commit_valid <= wb_valid;
            // Counter wraps at 16 bits
            if (wb_valid) begin
                commit_count <= commit_count + 1'b1;
            end
        end
    end

    // Reports the computed value, including writes aimed at register 0
    always_ff @(posedge clock) begin
        commit_rd   <= wb_rd;
        commit_data <= wb_data;
    end

    // Execute must hand over a resolved index and value with every write
    a_wb_known: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> !$isunknown({wb_rd, wb_data}))
        else $error("result: write-back carries unknown bits while wb_valid is high");

endmodule

`default_nettype wire

//--- hw/execute.sv
// Execute stage of the execution slice.
// Computes the ALU result of the operation held in decode's stage
// register, offers it back to decode as a bypass in the same cycle and
// registers it for the commit stage.

`default_nettype none

module execute (
    input  logic               clock,
    input  logic               reset,
    issue_if.consumer          issue,
    output logic               bypass_valid,
    output core_pkg::reg_idx_t bypass_rd,
    output core_pkg::data_t    bypass_data,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::data_t    wb_data
);

    core_pkg::data_t alu_result;

    // ALU, operand_b already carries the immediate forms
    always_comb begin
        case (issue.op)
            isa_pkg::OP_ADD:  alu_result = issue.operand_a + issue.operand_b;
            isa_pkg::OP_SUB:  alu_result = issue.operand_a - issue.operand_b;
            isa_pkg::OP_AND:  alu_result = issue.operand_a & issue.operand_b;
            isa_pkg::OP_OR:   alu_result = issue.operand_a | issue.operand_b;
            isa_pkg::OP_XOR:  alu_result = issue.operand_a ^ issue.operand_b;
            // Shift by low 5 bits only
            isa_pkg::OP_SLL:  alu_result = issue.operand_a << issue.operand_b[4:0];
            isa_pkg::OP_SRL:  alu_result = issue.operand_a >> issue.operand_b[4:0];
            isa_pkg::OP_ADDI: alu_result = issue.operand_a + issue.operand_b;
            // Upper half already placed by decode
            isa_pkg::OP_LUI:  alu_result = issue.operand_b;
            default:          alu_result = '0;
        endcase
    end

    // Distance-1 forwarding path into decode
    // Writes to register 0 are never forwarded
    assign bypass_valid = issue.valid && (issue.rd != '0);
    assign bypass_rd    = issue.rd;
    assign bypass_data  = alu_result;

    // Writeback stage register
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            // rd 0 still commits, only the bypass is held back
            wb_valid <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= issue.rd;
        wb_data <= alu_result;
    end

    // Decode's valid must stay resolved once out of reset
    a_issue_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(issue.valid))
        else $error("execute: issue.valid is unknown");

endmodule

`default_nettype wire

//--- hw/decode.sv
// Decode stage of the execution slice.
// Splits the instruction word, reads the register file, resolves operand
// hazards with the execute bypass and loads the issue stage register on
// the same edge that samples the instruction.

`default_nettype none

module decode (
    input  logic               clock,
    input  logic               reset,
    input  logic               inst_valid,
    input  isa_pkg::inst_t     inst,
    input  logic               bypass_valid,
    input  core_pkg::reg_idx_t bypass_rd,
    input  core_pkg::data_t    bypass_data,
    regfile_if.requester       rf,
    issue_if.producer          issue
);

    ////////////////////
    // Field extraction
    ////////////////////

    isa_pkg::opcode_t   op;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    isa_pkg::imm_t      imm;

    assign op  = inst[31:28];
    assign rd  = inst[27:24];
    assign rs1 = inst[23:20];
    assign rs2 = inst[19:16];
    assign imm = inst[15:0];

    // Register file read indices
    assign rf.rs1_idx = rs1;
    assign rf.rs2_idx = rs2;

    // Only ADD through LUI issue, NOP and unused codes drop out here
    logic op_known;
    assign op_known = (op >= isa_pkg::OP_ADD) && (op <= isa_pkg::OP_LUI);

    ////////////////////
    // Operand select
    ////////////////////

    core_pkg::data_t src_a;
    core_pkg::data_t src_b;
    core_pkg::data_t operand_b_sel;

    // Bypass from execute wins, register file already covers write-through
    // No index 0 check here, execute never raises bypass_valid for rd 0
    always_comb begin
        src_a = rf.rs1_data;
        if (bypass_valid && (bypass_rd == rs1)) begin
            src_a = bypass_data;
        end
        src_b = rf.rs2_data;
        if (bypass_valid && (bypass_rd == rs2)) begin
            src_b = bypass_data;
        end
    end

    // Immediate shaping for the two immediate forms
    always_comb begin
        case (op)
            isa_pkg::OP_ADDI: operand_b_sel = {{16{imm[15]}}, imm};
            isa_pkg::OP_LUI:  operand_b_sel = {imm, 16'h0000};
            default:          operand_b_sel = src_b;
        endcase
    end

    ////////////////////
    // Stage register
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= inst_valid && op_known;
        end
    end

    // Payload follows every edge, qualified by valid downstream
    always_ff @(posedge clock) begin
        issue.op        <= op;
        issue.rd        <= rd;
        issue.operand_a <= src_a;
        issue.operand_b <= operand_b_sel;
    end

    // Driver must present a clean word whenever the strobe is up
    a_inst_known: assert property (@(posedge clock) disable iff (reset)
        inst_valid |-> !$isunknown(inst))
        else $error("decode: inst has unknown bits while inst_valid is high");

endmodule

`default_nettype wire

//--- hw/regfile_if.sv
// Two combinational read ports into the register file.
// Decode supplies the indices, result returns the data in the same
// cycle, with write-through and register 0 forced to zero.

`default_nettype none

interface regfile_if;

    // Read indices from decode
    core_pkg::reg_idx_t rs1_idx;
    core_pkg::reg_idx_t rs2_idx;

    // Read data back from result
    core_pkg::data_t    rs1_data;
    core_pkg::data_t    rs2_data;

    modport requester (output rs1_idx, rs2_idx, input rs1_data, rs2_data);

    modport provider (input rs1_idx, rs2_idx, output rs1_data, rs2_data);

endinterface

`default_nettype wire

//--- hw/issue_if.sv
// Decoded operation passed from decode to execute.
// Decode drives it from its stage register, execute consumes it.
// valid is high for one cycle per real (non-NOP) operation.

`default_nettype none

interface issue_if;

    logic                 valid;
    isa_pkg::opcode_t     op;
    core_pkg::reg_idx_t   rd;
    // Source operands, already resolved
    core_pkg::data_t      operand_a;
    // Holds the shaped immediate for ADDI and LUI
    core_pkg::data_t      operand_b;

    modport producer (output valid, op, rd, operand_a, operand_b);

    modport consumer (input valid, op, rd, operand_a, operand_b);

endinterface

`default_nettype wire

//--- hw/core_pkg.sv
// Datapath types of the execution slice.
// Register values, register indices and the commit counter width.

`default_nettype none

package core_pkg;

    // One architectural register value
    typedef logic [31:0] data_t;

    // Register index, 16 registers
    typedef logic [3:0] reg_idx_t;

    // Commit counter, wraps at 16 bits
    typedef logic [15:0] count_t;

    // Size of the register file
    // Register 0 reads zero and ignores writes
    localparam int REG_COUNT = 16;

endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
// Instruction encoding of the execution slice.
// Word layout, field types and opcode values shared by decode, execute
// and the testbench. Referenced by scoped names only.

`default_nettype none

package isa_pkg;

    // Full instruction word
    // [31:28] opcode, [27:24] rd, [23:20] rs1, [19:16] rs2, [15:0] immediate
    typedef logic [31:0] inst_t;

    // Operation code field
    typedef logic [3:0] opcode_t;

    // Immediate field, signed for ADDI and upper half for LUI
    typedef logic [15:0] imm_t;

    // Register-register ALU operations
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_XOR  = 4'd5;
    // Shift amount is the low 5 bits of rs2
    localparam opcode_t OP_SLL  = 4'd6;
    localparam opcode_t OP_SRL  = 4'd7;

    // Immediate forms
    localparam opcode_t OP_ADDI = 4'd8;
    localparam opcode_t OP_LUI  = 4'd9;

    // Codes 10 to 15 are unused and behave as NOP

endpackage

`default_nettype wire
